// File: Makefile
SIM      := verilator
TOP      := socPeripheralHubTb
FILELIST := socPeripheralHub.f
BUILDDIR := obj_dir
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP)

SOURCES  := $(shell cat $(FILELIST))
BINARY   := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuild only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILDDIR) -f $(FILELIST)

# exit status of the simulator is the result
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILDDIR)

// File: hw/busDecoder.sv
`default_nettype none

module busDecoder (
    input  socBusPkg::busRequestT busReq,
    output logic                  ramRead,
    output logic                  ramWrite,
    output logic                  timerRead,
    output logic                  timerWrite,
    output logic                  irqRead,
    output socBusPkg::regionT     readRegion
);

    import socBusPkg::*;

    // top nibble of the byte address
    logic [$bits(busAddr_t)-1-regionShift:0] regionCode;

    assign regionCode = busReq.address[$bits(busAddr_t)-1:regionShift];

    // region lookup, anything unknown falls to none
    always_comb begin
        case (regionCode)
            regionRamCode: begin
                readRegion = regionRam;
            end
            regionTimerCode: begin
                readRegion = regionTimer;
            end
            regionIrqCode: begin
                readRegion = regionIrq;
            end
            default: begin
                readRegion = regionNone;
            end
        endcase
    end

    // ram takes both strobes
    assign ramRead = busReq.read && (readRegion == regionRam);
    assign ramWrite = busReq.write && (readRegion == regionRam);

    // timer register file
    assign timerRead = busReq.read && (readRegion == regionTimer);
    assign timerWrite = busReq.write && (readRegion == regionTimer);

    // interrupt block is read-only, writes dropped here
    assign irqRead = busReq.read && (readRegion == regionIrq);

    // unmapped reads strobe no slave
    // the return mux still answers them with zero

endmodule

`default_nettype wire

// File: hw/interruptController.sv
`default_nettype none

module interruptController (
    input  logic                    clk,
    input  logic                    rstN,
    input  socBusPkg::irqVector_t   triggerLines,
    input  logic                    interruptAcknowledge,
    input  socBusPkg::irqId_t       ackId,
    input  logic                    irqRead,
    output socBusPkg::busWord_t     pendingWord,
    output logic                    interruptRequest,
    output socBusPkg::irqId_t       interruptId
);

    import socBusPkg::*;

    // latched interrupt lines
    irqVector_t pending;

    // one-hot of the line being acknowledged
    irqVector_t ackMask;

    always_comb begin
        ackMask = '0;
        if (interruptAcknowledge) begin
            ackMask[ackId] = 1'b1;
        end
    end

    // clear first, then set, so a line firing
    // during its own acknowledge stays pending
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~ackMask) | triggerLines;
        end
    end

    // request while anything is pending
    assign interruptRequest = |pending;

    // priority scan, lowest index wins
    // walk downwards so the last hit is the lowest
    always_comb begin
        interruptId = '0;
        for (int i = $bits(irqVector_t) - 1; i >= 0; i--) begin
            if (pending[i]) begin
                interruptId = irqId_t'(i);
            end
        end
    end

    // status read, pending zero-extended to a bus word
    // any word offset in the region lands here
    always_ff @(posedge clk) begin
        if (irqRead) begin
            pendingWord <= busWord_t'(pending);
        end
    end

endmodule

`default_nettype wire

// File: hw/intervalTimer.sv
`default_nettype none

module intervalTimer (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                timerRead,
    input  logic                                timerWrite,
    input  socBusPkg::timerRegAddr_t            regIndex,
    input  socBusPkg::busWord_t                 writeData,
    output socBusPkg::busWord_t                 readData,
    output logic [socBusPkg::timerCount-1:0]    timerIrq
);

    import socBusPkg::*;

    // per channel reload and live count
    busWord_t reload [timerCount];
    busWord_t count [timerCount];

    // control register, one enable bit per channel
    logic [timerCount-1:0] enable;

    // enabled channel sitting at zero this cycle
    logic [timerCount-1:0] expired;

    // selected register for the read port
    busWord_t readMux;

    always_comb begin
        for (int i = 0; i < timerCount; i++) begin
            expired[i] = enable[i] && (count[i] == '0);
        end
    end

    // irq pulses in the cycle the count hits zero
    // reload happens in the same cycle, so period is reload+1
    assign timerIrq = expired;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enable <= '0;
            for (int i = 0; i < timerCount; i++) begin
                reload[i] <= '0;
                count[i] <= '0;
            end
        end else begin
            // enables live in the low bits of control
            if (timerWrite && (regIndex == timerCtrlIndex)) begin
                enable <= writeData[timerCount-1:0];
            end
            for (int i = 0; i < timerCount; i++) begin
                if (timerWrite && (regIndex == timerRegAddr_t'(i))) begin
                    // new reload also restarts the count
                    reload[i] <= writeData;
                    count[i] <= writeData;
                end else if (expired[i]) begin
                    count[i] <= reload[i];
                end else if (enable[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
                // disabled channels hold their count
            end
        end
    end

    // register file read decode
    // count registers are read-only, index 7 reads zero
    always_comb begin
        readMux = '0;
        if (regIndex == timerCtrlIndex) begin
            readMux = busWord_t'(enable);
        end
        for (int i = 0; i < timerCount; i++) begin
            if (regIndex == timerRegAddr_t'(i)) begin
                readMux = reload[i];
            end
            if (regIndex == timerCountBase + timerRegAddr_t'(i)) begin
                readMux = count[i];
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (timerRead) begin
            readData <= readMux;
        end
    end

endmodule

`default_nettype wire

// File: hw/readReturnMux.sv
`default_nettype none

module readReturnMux (
    input  logic                clk,
    input  logic                rstN,
    input  socBusPkg::regionT   readRegion,
    input  logic                anyRead,
    input  socBusPkg::busWord_t ramData,
    input  socBusPkg::busWord_t timerData,
    input  socBusPkg::busWord_t irqData,
    output socBusPkg::busWord_t busReadData,
    output logic                readValid
);

    import socBusPkg::*;

    // region of the read now returning
    regionT pendingRegion;

    // slaves answer one cycle after the strobe
    // so a single stage of tracking covers it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
            pendingRegion <= regionNone;
        end else begin
            readValid <= anyRead;
            if (anyRead) begin
                pendingRegion <= readRegion;
            end
        end
    end

    // pick the slave word, unmapped reads give zero
    always_comb begin
        case (pendingRegion)
            regionRam:   busReadData = ramData;
            regionTimer: busReadData = timerData;
            regionIrq:   busReadData = irqData;
            default:     busReadData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/scratchRam.sv
`default_nettype none

module scratchRam (
    input  logic                    clk,
    input  logic                    ramRead,
    input  logic                    ramWrite,
    input  socBusPkg::ramWordAddr_t wordAddr,
    input  socBusPkg::byteEnable_t  bwe,
    input  socBusPkg::busWord_t     writeData,
    output socBusPkg::busWord_t     readData
);

    import socBusPkg::*;

    // plain block ram array
    busWord_t mem [ramDepth];

    // byte lanes of one word
    localparam int laneCount = $bits(byteEnable_t);
    localparam int laneWidth = $bits(busWord_t) / laneCount;

    // write port, only enabled lanes change
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            for (int lane = 0; lane < laneCount; lane++) begin
                if (bwe[lane]) begin
                    mem[wordAddr][lane*laneWidth +: laneWidth] <=
                        writeData[lane*laneWidth +: laneWidth];
                end
            end
        end
    end

    // registered read, data valid the cycle after the strobe
    // a write in cycle t is seen by a read in t+1
    always_ff @(posedge clk) begin
        if (ramRead) begin
            readData <= mem[wordAddr];
        end
    end

    // read and write never share a cycle on this bus
    // so no read-during-write ordering is needed

endmodule

`default_nettype wire

// File: hw/socBusPkg.sv
`default_nettype none

package socBusPkg;

    // bus data word and byte address
    typedef logic [31:0] busWord_t;
    typedef logic [31:0] busAddr_t;

    // bit n enables byte n of the word
    typedef logic [3:0] byteEnable_t;

    // word index inside the scratch ram
    typedef logic [11:0] ramWordAddr_t;

    // timer register index, address bits 4:2
    typedef logic [2:0] timerRegAddr_t;

    // interrupt lines and interrupt number
    typedef logic [15:0] irqVector_t;
    typedef logic [3:0] irqId_t;

    // scratch ram size in words, 16 KiB
    localparam int ramDepth = 4096;

    // address bits 31:28 pick the region
    localparam int regionShift = 28;
    localparam logic [31-regionShift:0] regionRamCode = 0;
    localparam logic [31-regionShift:0] regionTimerCode = 1;
    localparam logic [31-regionShift:0] regionIrqCode = 2;

    // timer channels, wired to the lowest interrupt lines
    localparam int timerCount = 3;
    localparam int timerIrqBase = 0;

    // register 3 holds the channel enables
    localparam timerRegAddr_t timerCtrlIndex = 3'd3;
    // registers 4 to 6 read back the live counts
    localparam timerRegAddr_t timerCountBase = 3'd4;

    // everything the master drives in one cycle
    typedef struct packed {
        logic        read;
        logic        write;
        byteEnable_t bwe;
        busAddr_t    address;
        busWord_t    data;
    } busRequestT;

    // decoded target of a request
    typedef enum logic [1:0] {
        regionRam,
        regionTimer,
        regionIrq,
        regionNone
    } regionT;

endpackage

`default_nettype wire

// File: hw/socPeripheralHub.sv
`default_nettype none

module socPeripheralHub (
    input  logic                    clk,
    input  logic                    rstN,
    input  socBusPkg::busRequestT   busReq,
    output socBusPkg::busWord_t     busReadData,
    output logic                    readValid,
    input  logic [$bits(socBusPkg::irqVector_t)-socBusPkg::timerCount-1:0] extIrq,
    output logic                    interruptRequest,
    output socBusPkg::irqId_t       interruptId,
    input  logic                    interruptAcknowledge,
    input  socBusPkg::irqId_t       ackId
);

    import socBusPkg::*;

    // decoded strobes
    logic       ramRead;
    logic       ramWrite;
    logic       timerRead;
    logic       timerWrite;
    logic       irqRead;
    regionT     readRegion;

    // slave read data
    busWord_t   ramData;
    busWord_t   timerData;
    busWord_t   irqData;

    // interrupt lines
    logic [timerCount-1:0] timerIrq;
    irqVector_t            triggerLines;

    // timers on the low lines, outside sources above them
    assign triggerLines[timerIrqBase +: timerCount] = timerIrq;
    assign triggerLines[timerIrqBase + timerCount +: $bits(extIrq)] = extIrq;

    busDecoder
    busDecoder (
        .busReq,
        .ramRead,
        .ramWrite,
        .timerRead,
        .timerWrite,
        .irqRead,
        .readRegion
    );

    // word index is byte address bits 13:2
    scratchRam
    scratchRam (
        .clk,
        .ramRead,
        .ramWrite,
        .wordAddr               (busReq.address[2 +: $bits(ramWordAddr_t)]),
        .bwe                    (busReq.bwe),
        .writeData              (busReq.data),
        .readData               (ramData)
    );

    // register index is byte address bits 4:2
    intervalTimer
    intervalTimer (
        .clk,
        .rstN,
        .timerRead,
        .timerWrite,
        .regIndex               (busReq.address[2 +: $bits(timerRegAddr_t)]),
        .writeData              (busReq.data),
        .readData               (timerData),
        .timerIrq
    );

    interruptController
    interruptController (
        .clk,
        .rstN,
        .triggerLines,
        .interruptAcknowledge,
        .ackId,
        .irqRead,
        .pendingWord            (irqData),
        .interruptRequest,
        .interruptId
    );

    readReturnMux
    readReturnMux (
        .clk,
        .rstN,
        .readRegion,
        .anyRead                (busReq.read),
        .ramData,
        .timerData,
        .irqData,
        .busReadData,
        .readValid
    );

endmodule

`default_nettype wire

// File: socPeripheralHub.f
hw/socBusPkg.sv
hw/busDecoder.sv
hw/scratchRam.sv
hw/intervalTimer.sv
hw/interruptController.sv
hw/readReturnMux.sv
hw/socPeripheralHub.sv
verif/socPeripheralHub_checker.sv
verif/socPeripheralHubTb.sv

// File: verif/socPeripheralHubTb.sv
`default_nettype none

module socPeripheralHubTb;

    timeunit 1ns;
    timeprecision 1ps;

    import socBusPkg::*;

    // generous bound over the whole directed run
    localparam int timeoutCycles = 2000;
    // inputs move this long after the rising edge
    localparam time driveDelay = 2ns;
    // outside lines sit above the timer lines
    localparam int extCount = $bits(irqVector_t) - timerCount;

    typedef logic [extCount-1:0] extLines_t;

    logic       clk = 1'b0;
    logic       rstN;
    busRequestT busReq;
    busWord_t   busReadData;
    logic       readValid;
    extLines_t  extIrq;
    logic       interruptRequest;
    irqId_t     interruptId;
    logic       interruptAcknowledge;
    irqId_t     ackId;

    // xorshift state and cycle counter
    busWord_t   rngState;
    int         cycleCount = 0;

    // shadow of written ram words, keyed by word index
    busWord_t     ramModel [int];
    ramWordAddr_t ramIndex [16];

    socPeripheralHub uut (
        .clk,
        .rstN,
        .busReq,
        .busReadData,
        .readValid,
        .extIrq,
        .interruptRequest,
        .interruptId,
        .interruptAcknowledge,
        .ackId
    );

    // 20 ns period
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("ERROR: %0t ns run did not finish within %0d cycles", $time, timeoutCycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    function automatic busWord_t nextRandom();
        busWord_t x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // region in bits 31:28, word index from bit 2 up
    function automatic busAddr_t regionAddr(input logic [3:0] region, input logic [11:0] word);
        return {region, 14'h0, word, 2'b00};
    endfunction

    // interrupt id 3 is outside line 0
    function automatic extLines_t extLine(input int id);
        extLines_t lines;
        lines = '0;
        lines[id - timerCount] = 1'b1;
        return lines;
    endfunction

    task automatic checkValue(input string name, input busWord_t expected, input busWord_t actual);
        assert (actual === expected) else begin
            $display("ERROR: %0t ns %s expected %h got %h", $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic busWrite(input busAddr_t addr, input busWord_t data, input byteEnable_t bwe);
        busReq.write = 1'b1;
        busReq.address = addr;
        busReq.data = data;
        busReq.bwe = bwe;
        @(posedge clk);
        #driveDelay;
        busReq.write = 1'b0;
    endtask

    // data returns one cycle after the strobe
    task automatic busRead(input busAddr_t addr, output busWord_t data);
        busReq.read = 1'b1;
        busReq.address = addr;
        @(posedge clk);
        #driveDelay;
        busReq.read = 1'b0;
        checkValue("readValid", 32'd1, busWord_t'(readValid));
        data = busReadData;
    endtask

    task automatic readCheck(input busAddr_t addr, input busWord_t expected);
        busWord_t data;
        busRead(addr, data);
        checkValue("busReadData", expected, data);
    endtask

    task automatic pulseIrq(input extLines_t lines);
        extIrq = lines;
        @(posedge clk);
        #driveDelay;
        extIrq = '0;
    endtask

    task automatic acknowledge(input irqId_t id);
        interruptAcknowledge = 1'b1;
        ackId = id;
        @(posedge clk);
        #driveDelay;
        interruptAcknowledge = 1'b0;
    endtask

    task automatic ramAccess();
        busWord_t    data;
        busWord_t    merged;
        byteEnable_t bwe;
        for (int i = 0; i < 16; i++) begin
            ramIndex[i] = ramWordAddr_t'(nextRandom());
            data = nextRandom();
            busWrite(regionAddr(regionRamCode, ramIndex[i]), data, 4'hF);
            ramModel[ramIndex[i]] = data;
        end
        // partial rewrites, byte n follows bwe bit n
        for (int i = 0; i < 6; i++) begin
            data = nextRandom();
            bwe = byteEnable_t'(nextRandom());
            merged = ramModel[ramIndex[i]];
            for (int lane = 0; lane < 4; lane++) begin
                if (bwe[lane]) begin
                    merged[lane*8 +: 8] = data[lane*8 +: 8];
                end
            end
            busWrite(regionAddr(regionRamCode, ramIndex[i]), data, bwe);
            ramModel[ramIndex[i]] = merged;
        end
        // reads issued every cycle
        for (int i = 0; i < 16; i++) begin
            readCheck(regionAddr(regionRamCode, ramIndex[i]), ramModel[ramIndex[i]]);
        end
    endtask

    task automatic unmappedRead();
        busWrite(regionAddr(4'h5, ramIndex[0]), ~ramModel[ramIndex[0]], 4'hF);
        readCheck(regionAddr(4'h5, ramIndex[0]), 32'h0);
        readCheck(regionAddr(regionRamCode, ramIndex[0]), ramModel[ramIndex[0]]);
    endtask

    task automatic timerCountdown();
        busWord_t first;
        busWord_t second;
        int       waited;
        busWrite(regionAddr(regionTimerCode, 12'd1), 32'd40, 4'hF);
        readCheck(regionAddr(regionTimerCode, 12'd5), 32'd40);
        // run channel 1 for a while, then freeze it
        busWrite(regionAddr(regionTimerCode, 12'd3), 32'h2, 4'hF);
        repeat (10) @(posedge clk);
        #driveDelay;
        busWrite(regionAddr(regionTimerCode, 12'd3), 32'h0, 4'hF);
        busRead(regionAddr(regionTimerCode, 12'd5), first);
        busRead(regionAddr(regionTimerCode, 12'd5), second);
        assert (first < 32'd40) else begin
            $display("ERROR: %0t ns timer count %0d did not fall below 40", $time, first);
            $display("Test failures found");
            $fatal(1, "timer did not count");
        end
        checkValue("frozen count", first, second);
        busWrite(regionAddr(regionTimerCode, 12'd3), 32'h2, 4'hF);
        waited = 0;
        while (!interruptRequest && waited < 50) begin
            @(posedge clk);
            #driveDelay;
            waited++;
        end
        assert (interruptRequest) else begin
            $display("ERROR: %0t ns timer channel 1 raised no interrupt in 50 cycles", $time);
            $display("Test failures found");
            $fatal(1, "no timer interrupt");
        end
        checkValue("interruptId", 32'd1, busWord_t'(interruptId));
        acknowledge(4'd1);
        busWrite(regionAddr(regionTimerCode, 12'd3), 32'h0, 4'hF);
        checkValue("interruptRequest", 32'd0, busWord_t'(interruptRequest));
    endtask

    task automatic irqPriority();
        pulseIrq(extLine(9) | extLine(4));
        checkValue("interruptRequest", 32'd1, busWord_t'(interruptRequest));
        checkValue("interruptId", 32'd4, busWord_t'(interruptId));
        acknowledge(4'd4);
        checkValue("interruptId", 32'd9, busWord_t'(interruptId));
        acknowledge(4'd9);
        checkValue("interruptRequest", 32'd0, busWord_t'(interruptRequest));
    endtask

    task automatic pendingReadback();
        pulseIrq(extLine(3) | extLine(7) | extLine(15));
        // any word offset of region 2 reads pending
        readCheck(regionAddr(regionIrqCode, 12'd9), (32'd1 << 3) | (32'd1 << 7) | (32'd1 << 15));
        acknowledge(4'd3);
        acknowledge(4'd7);
        acknowledge(4'd15);
        readCheck(regionAddr(regionIrqCode, 12'd0), 32'h0);
    endtask

    initial begin
        rstN = 1'b0;
        busReq = '0;
        extIrq = '0;
        interruptAcknowledge = 1'b0;
        ackId = '0;
        rngState = 32'd34210;
        repeat (3) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        // idle state straight out of reset
        checkValue("readValid", 32'd0, busWord_t'(readValid));
        checkValue("interruptRequest", 32'd0, busWord_t'(interruptRequest));
        readCheck(regionAddr(regionTimerCode, 12'd4), 32'h0);
        ramAccess();
        unmappedRead();
        timerCountdown();
        irqPriority();
        pendingReadback();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/socPeripheralHub_checker.sv
`default_nettype none

module socPeripheralHub_checker (
    input logic                  clk,
    input logic                  rstN,
    input socBusPkg::busRequestT busReq,
    input logic                  readValid,
    input logic                  interruptRequest,
    input socBusPkg::irqVector_t triggerLines
);

    timeunit 1ns;
    timeprecision 1ps;

    // every read strobe is answered on the next cycle
    readAnswered: assert property (@(posedge clk) disable iff (!rstN)
        busReq.read |=> readValid)
        else $error("readValid missing one cycle after a read");

    // no answer without a read the cycle before
    noSpuriousValid: assert property (@(posedge clk) disable iff (!rstN)
        !busReq.read |=> !readValid)
        else $error("readValid high with no read in the previous cycle");

    // any line firing shows up as a request one cycle later
    lineRaisesRequest: assert property (@(posedge clk) disable iff (!rstN)
        (triggerLines != '0) |=> interruptRequest)
        else $error("interruptRequest missing one cycle after an interrupt line");

    // plain strobes, one direction per cycle
    strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(busReq.read && busReq.write))
        else $error("read and write strobes high together");

endmodule

// sixteen-line vector as the top joins it
bind socPeripheralHub socPeripheralHub_checker hubChecker (
    .clk,
    .rstN,
    .busReq,
    .readValid,
    .interruptRequest,
    .triggerLines
);

`default_nettype wire
